// ==== rtl/stbuf_settings.svh ====
/* Sizes for the store buffer. The line width must be a multiple of 32 bits
   and the strand count must stay 4, as strand indices are 2 bits wide */
`ifndef STBUF_SETTINGS_SVH
`define STBUF_SETTINGS_SVH

// One pending-store slot per strand
`define STBUF_STRANDS 4

`define STBUF_TAG_W 21
`define STBUF_SET_W 5
`define STBUF_LINE_W 512
`define STBUF_MASK_W (`STBUF_LINE_W / 8)
`define STBUF_ADDR_W (`STBUF_TAG_W + `STBUF_SET_W)

// Id of this unit on the shared L2 bus
`define STBUF_UNIT_ID 2
`endif

// ==== rtl/stbuf_pkg.sv ====
/* Types on the core side of the store buffer: the request port, the data
   returned to a load, and the per-slot status flags */
package stbuf_pkg;
`include "stbuf_settings.svh"

	typedef logic [1:0] strand_t;

	// One request per cycle from the core, valid for a single cycle
	typedef struct packed {
		logic valid;
		logic write;
		logic sync;
		strand_t strand;
		logic [`STBUF_TAG_W-1:0] tag;
		logic [`STBUF_SET_W-1:0] set;
		logic [`STBUF_LINE_W-1:0] data;
		logic [`STBUF_MASK_W-1:0] mask;
	} core_req_t;

	// Mask has one bit per byte of data
	typedef struct packed {
		logic [`STBUF_LINE_W-1:0] data;
		logic [`STBUF_MASK_W-1:0] mask;
	} bypass_t;

	typedef struct packed {
		logic occupied;
		logic pending;
		logic hit;
		logic sync_wait;
		logic sync_done;
		logic sync_result;
	} slot_stat_t;

endpackage

// ==== rtl/l2_pkg.sv ====
/* Types of the L2 request and response buses. The way field is not carried,
   as the L2 takes the way from its own directory */
package l2_pkg;
`include "stbuf_settings.svh"

	typedef enum logic [2:0] {
		L2_OP_STORE = 3'b001,
		L2_OP_STORE_SYNC = 3'b101
	} l2_op_e;

	typedef struct packed {
		logic [1:0] unit;
		logic [1:0] strand;
		l2_op_e op;
		logic [`STBUF_ADDR_W-1:0] address;
		logic [`STBUF_LINE_W-1:0] data;
		logic [`STBUF_MASK_W-1:0] mask;
	} l2_req_t;

	// Broadcast to all units; valid lasts one cycle
	typedef struct packed {
		logic valid;
		logic status;
		logic [1:0] unit;
		logic [1:0] strand;
	} l2_rsp_t;

endpackage

// ==== rtl/store_slot.sv ====
/* Holds the single pending store of one strand. A write in the cycle of the
   L2 completion replaces the old store, so the caller must only write when allowed */
`timescale 1ns/1ns
`include "stbuf_settings.svh"

module store_slot
	import stbuf_pkg::*, l2_pkg::*;
#(
	parameter strand_t STRAND = '0
)
(
	input logic clk,
	input logic arst_n_i,
	input logic wr_i,
	input core_req_t req_i,
	input logic issued_i,
	input logic complete_i,
	input logic status_i,
	output slot_stat_t stat_o,
	output bypass_t byp_o,
	output l2_req_t l2_o
);

	logic occupied_q;
	logic issued_q;
	logic sync_wait_q;
	logic sync_done_q;
	logic sync_result_q;
	logic [`STBUF_TAG_W-1:0] tag_q;
	logic [`STBUF_SET_W-1:0] set_q;
	logic [`STBUF_LINE_W-1:0] data_q;
	logic [`STBUF_MASK_W-1:0] mask_q;
	logic sync_q;
	logic own_sync_req;

	// Any synchronized write from this strand starts a new sync sequence
	assign own_sync_req = req_i.valid && req_i.write && req_i.sync && req_i.strand == STRAND;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			occupied_q <= 1'b0;
			issued_q <= 1'b0;
			sync_wait_q <= 1'b0;
			sync_done_q <= 1'b0;
			sync_result_q <= 1'b0;
		end
		else
		begin
			// A new store wins over the completion of the old one
			if (wr_i)
			begin
				occupied_q <= 1'b1;
				issued_q <= 1'b0;
			end
			else if (complete_i)
			begin
				occupied_q <= 1'b0;
				issued_q <= 1'b0;
			end
			else if (issued_i)
				issued_q <= 1'b1;

			if (wr_i && req_i.sync)
				sync_wait_q <= 1'b1;
			else if (complete_i)
				sync_wait_q <= 1'b0;

			if (complete_i && sync_wait_q)
			begin
				sync_done_q <= 1'b1;
				sync_result_q <= status_i;
			end
			else if (own_sync_req)
				sync_done_q <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_i)
		begin
			tag_q <= req_i.tag;
			set_q <= req_i.set;
			data_q <= req_i.data;
			mask_q <= req_i.mask;
			sync_q <= req_i.sync;
		end
	end

	assign stat_o.occupied = occupied_q;
	assign stat_o.pending = occupied_q && !issued_q;
	assign stat_o.hit = occupied_q && req_i.tag == tag_q && req_i.set == set_q;
	assign stat_o.sync_wait = sync_wait_q;
	assign stat_o.sync_done = sync_done_q;
	assign stat_o.sync_result = sync_result_q;

	assign byp_o.data = data_q;
	assign byp_o.mask = mask_q;

	assign l2_o.unit = 2'(`STBUF_UNIT_ID);
	assign l2_o.strand = STRAND;
	assign l2_o.op = sync_q ? L2_OP_STORE_SYNC : L2_OP_STORE;
	assign l2_o.address = {tag_q, set_q};
	assign l2_o.data = data_q;
	assign l2_o.mask = mask_q;

endmodule

// ==== rtl/store_admit.sv ====
/* Front end of the store buffer. Bypass, rollback and resume are registered,
   so they appear one cycle after the request or the L2 response */
`timescale 1ns/1ns
`include "stbuf_settings.svh"

module store_admit
	import stbuf_pkg::*;
(
	input logic clk,
	input logic arst_n_i,
	input core_req_t core_req_i,
	input slot_stat_t [`STBUF_STRANDS-1:0] stat_i,
	input bypass_t [`STBUF_STRANDS-1:0] slot_byp_i,
	input logic [`STBUF_STRANDS-1:0] complete_i,
	output logic [`STBUF_STRANDS-1:0] slot_wr_o,
	output bypass_t bypass_o,
	output logic rollback_o,
	output logic [`STBUF_STRANDS-1:0] resume_o
);

	slot_stat_t cur_stat;
	logic wr;
	logic slot_free;
	logic sync_first;
	logic accept;
	logic full_rb;
	logic sync_rb;
	logic sync_ret;
	logic [`STBUF_STRANDS-1:0] wait_full_q;
	logic [`STBUF_STRANDS-1:0] full_mask;
	logic [`STBUF_STRANDS-1:0] sync_wait_vec;

	assign cur_stat = stat_i[core_req_i.strand];
	assign wr = core_req_i.valid && core_req_i.write;

	// A slot completing this cycle counts as free
	assign slot_free = !cur_stat.occupied || complete_i[core_req_i.strand];
	assign sync_first = core_req_i.sync && !cur_stat.sync_done;

	assign accept = wr && slot_free && (!core_req_i.sync || sync_first);
	assign full_rb = wr && !slot_free;
	assign sync_rb = wr && slot_free && sync_first;

	// Retry of a finished synchronized store just reports the L2 status
	assign sync_ret = wr && core_req_i.sync && cur_stat.sync_done;

	always_comb
	begin
		slot_wr_o = '0;
		full_mask = '0;
		if (accept)
			slot_wr_o[core_req_i.strand] = 1'b1;
		if (full_rb)
			full_mask[core_req_i.strand] = 1'b1;
	end

	always_comb
	begin
		for (int i = 0; i < `STBUF_STRANDS; i++)
			sync_wait_vec[i] = stat_i[i].sync_wait;
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			wait_full_q <= '0;
			rollback_o <= 1'b0;
			resume_o <= '0;
		end
		else
		begin
			wait_full_q <= (wait_full_q & ~complete_i) | full_mask;
			rollback_o <= full_rb || sync_rb;
			resume_o <= complete_i & (wait_full_q | sync_wait_vec);
		end
	end

	always_ff @(posedge clk)
	begin
		if (sync_ret)
		begin
			bypass_o.mask <= '1;
			bypass_o.data <= {(`STBUF_LINE_W / 32){{31'b0, cur_stat.sync_result}}};
		end
		else if (core_req_i.valid && cur_stat.hit)
			bypass_o <= slot_byp_i[core_req_i.strand];
		else
			bypass_o <= '0;
	end

endmodule

// ==== rtl/l2_store_issue.sv ====
/* Drains pending slots to L2 one at a time over a four-phase req/ack handshake.
   Responses are taken as one-cycle pulses and only those for this unit count */
`timescale 1ns/1ns
`include "stbuf_settings.svh"

module l2_store_issue
	import stbuf_pkg::*, l2_pkg::*;
(
	input logic clk,
	input logic arst_n_i,
	input slot_stat_t [`STBUF_STRANDS-1:0] stat_i,
	input l2_req_t [`STBUF_STRANDS-1:0] slot_l2_i,
	output l2_req_t l2_req_o,
	output logic l2_req_valid_o,
	input logic l2_ack_i,
	input l2_rsp_t l2_rsp_i,
	output logic [`STBUF_STRANDS-1:0] issued_o,
	output logic [`STBUF_STRANDS-1:0] complete_o,
	output logic status_o
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_DROP
	} hs_state_e;

	hs_state_e state_q;
	strand_t sel_q;
	strand_t rr_ptr_q;
	strand_t grant_idx;
	logic grant_found;
	logic rsp_hit;

	// Search starts at the strand after the last one granted
	always_comb
	begin
		strand_t idx;
		grant_found = 1'b0;
		grant_idx = rr_ptr_q;
		for (int k = 0; k < `STBUF_STRANDS; k++)
		begin
			idx = rr_ptr_q + strand_t'(k);
			if (!grant_found && stat_i[idx].pending)
			begin
				grant_found = 1'b1;
				grant_idx = idx;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= ST_IDLE;
			sel_q <= '0;
			rr_ptr_q <= '0;
		end
		else
		begin
			case (state_q)
				ST_IDLE, ST_DROP:
				begin
					// Phase 4 must be seen before the next req may rise
					if (!l2_ack_i)
					begin
						if (grant_found)
						begin
							sel_q <= grant_idx;
							rr_ptr_q <= grant_idx + strand_t'(1);
							state_q <= ST_REQ;
						end
						else
							state_q <= ST_IDLE;
					end
				end
				ST_REQ:
				begin
					if (l2_ack_i)
						state_q <= ST_DROP;
				end
				default:
					state_q <= ST_IDLE;
			endcase
		end
	end

	// The selected slot cannot change while its store is in the handshake
	assign l2_req_o = slot_l2_i[sel_q];
	assign l2_req_valid_o = state_q == ST_REQ;

	always_comb
	begin
		issued_o = '0;
		complete_o = '0;
		if (state_q == ST_REQ && l2_ack_i)
			issued_o[sel_q] = 1'b1;
		if (rsp_hit)
			complete_o[l2_rsp_i.strand] = 1'b1;
	end

	assign rsp_hit = l2_rsp_i.valid && l2_rsp_i.unit == 2'(`STBUF_UNIT_ID);
	assign status_o = l2_rsp_i.status;

endmodule

// ==== rtl/store_buffer.sv ====
/* L1 store buffer for a four-strand core, one pending store per strand.
   The core never stalls here; a store that cannot be taken is rolled back */
`timescale 1ns/1ns
`include "stbuf_settings.svh"

module store_buffer
	import stbuf_pkg::*, l2_pkg::*;
(
	input logic clk,
	input logic arst_n_i,
	input core_req_t core_req_i,
	output bypass_t bypass_o,
	output logic rollback_o,
	output logic [`STBUF_STRANDS-1:0] resume_o,
	output l2_req_t l2_req_o,
	output logic l2_req_valid_o,
	input logic l2_ack_i,
	input l2_rsp_t l2_rsp_i
);

	slot_stat_t [`STBUF_STRANDS-1:0] slot_stat;
	bypass_t [`STBUF_STRANDS-1:0] slot_byp;
	l2_req_t [`STBUF_STRANDS-1:0] slot_l2;
	logic [`STBUF_STRANDS-1:0] slot_wr;
	logic [`STBUF_STRANDS-1:0] issued;
	logic [`STBUF_STRANDS-1:0] complete;
	logic l2_status;

	store_admit u_admit (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.core_req_i(core_req_i),
		.stat_i(slot_stat),
		.slot_byp_i(slot_byp),
		.complete_i(complete),
		.slot_wr_o(slot_wr),
		.bypass_o(bypass_o),
		.rollback_o(rollback_o),
		.resume_o(resume_o)
	);

	for (genvar i = 0; i < `STBUF_STRANDS; i++)
	begin : g_slot
		store_slot #(
			.STRAND(strand_t'(i))
		) u_slot (
			.clk(clk),
			.arst_n_i(arst_n_i),
			.wr_i(slot_wr[i]),
			.req_i(core_req_i),
			.issued_i(issued[i]),
			.complete_i(complete[i]),
			.status_i(l2_status),
			.stat_o(slot_stat[i]),
			.byp_o(slot_byp[i]),
			.l2_o(slot_l2[i])
		);
	end

	l2_store_issue u_issue (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.stat_i(slot_stat),
		.slot_l2_i(slot_l2),
		.l2_req_o(l2_req_o),
		.l2_req_valid_o(l2_req_valid_o),
		.l2_ack_i(l2_ack_i),
		.l2_rsp_i(l2_rsp_i),
		.issued_o(issued),
		.complete_o(complete),
		.status_o(l2_status)
	);

endmodule

// ==== tests/store_buffer_props.sv ====
/* Handshake and response rules for l2_store_issue, attached by bind.
   Only responses addressed to this unit are checked against the strands in flight */
`timescale 1ns/1ns
`include "stbuf_settings.svh"

module store_buffer_props
	import l2_pkg::*;
(
	input logic clk,
	input logic arst_n_i,
	input l2_req_t l2_req_o,
	input logic l2_req_valid_o,
	input logic l2_ack_i,
	input l2_rsp_t l2_rsp_i,
	input logic [`STBUF_STRANDS-1:0] issued_o,
	input logic [`STBUF_STRANDS-1:0] complete_o
);

	int failures = 0;
	logic [`STBUF_STRANDS-1:0] in_flight_q;
	logic hs_busy;
	logic own_rsp;

	// The handshake is busy from the rise of req until ack falls
	assign hs_busy = l2_req_valid_o || l2_ack_i;
	assign own_rsp = l2_rsp_i.valid && l2_rsp_i.unit == 2'(`STBUF_UNIT_ID);

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			in_flight_q <= '0;
		else
			in_flight_q <= (in_flight_q | issued_o) & ~complete_o;
	end

	a_req_held: assert property (@(posedge clk) disable iff (!arst_n_i)
		l2_req_valid_o && !l2_ack_i |=> l2_req_valid_o)
	else
	begin
		$error("L2 req fell before ack");
		failures++;
	end

	a_payload_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
		hs_busy |=> !hs_busy || $stable(l2_req_o))
	else
	begin
		$error("L2 payload changed during the handshake");
		failures++;
	end

	a_no_rise_on_ack: assert property (@(posedge clk) disable iff (!arst_n_i)
		!l2_req_valid_o && l2_ack_i |=> !l2_req_valid_o)
	else
	begin
		$error("L2 req rose while ack was still high");
		failures++;
	end

	a_rsp_issued: assert property (@(posedge clk) disable iff (!arst_n_i)
		own_rsp |-> in_flight_q[l2_rsp_i.strand])
	else
	begin
		$error("L2 response for strand %0d that has no store in flight", l2_rsp_i.strand);
		failures++;
	end

endmodule

bind l2_store_issue store_buffer_props u_props (
	.clk(clk),
	.arst_n_i(arst_n_i),
	.l2_req_o(l2_req_o),
	.l2_req_valid_o(l2_req_valid_o),
	.l2_ack_i(l2_ack_i),
	.l2_rsp_i(l2_rsp_i),
	.issued_o(issued_o),
	.complete_o(complete_o)
);

// ==== tests/store_buffer_tb.sv ====
/* Replays tests/store_patterns.hex against the store buffer, so it runs from the
   project root. The L2 model serves one handshake at a time */
`timescale 1ns/1ns
`include "stbuf_settings.svh"

module store_buffer_tb
	import stbuf_pkg::*, l2_pkg::*;
();

	localparam int STEP_W = 8;
	localparam int MAX_STEPS = 40;
	localparam int WAIT_LIMIT = 200;
	localparam int QUIET_CYCLES = 8;

	logic clk = 1'b0;
	logic arst_n_i = 1'b0;
	core_req_t core_req = '0;
	bypass_t bypass;
	logic rollback;
	logic [`STBUF_STRANDS-1:0] resume;
	l2_req_t l2_req;
	logic l2_req_valid;
	logic l2_ack = 1'b0;
	l2_rsp_t l2_rsp = '0;

	logic [63:0] pat [0:MAX_STEPS*STEP_W-1];
	l2_req_t exp_l2 [`STBUF_STRANDS];
	logic exp_valid [`STBUF_STRANDS];
	strand_t grant_log [$];
	int errors = 0;
	int test_errors = 0;
	int test_num = 0;

	// L2 model states are 0 idle, 1 ack delay, 2 wait for req low and 3 response delay
	int m_state = 0;
	int ack_wait = 0;
	int rsp_wait = 0;
	l2_req_t m_req;

	always #2 clk = ~clk;

	store_buffer UUT (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.core_req_i(core_req),
		.bypass_o(bypass),
		.rollback_o(rollback),
		.resume_o(resume),
		.l2_req_o(l2_req),
		.l2_req_valid_o(l2_req_valid),
		.l2_ack_i(l2_ack),
		.l2_rsp_i(l2_rsp)
	);

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERR %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bypass(input bypass_t got, input bypass_t exp);
		if (got.data !== exp.data)
		begin
			$display("ERR bypass_o.data: got %h expected %h", got.data, exp.data);
			errors++;
		end
		if (got.mask !== exp.mask)
		begin
			$display("ERR bypass_o.mask: got %h expected %h", got.mask, exp.mask);
			errors++;
		end
	endtask

	task automatic check_l2_req(input l2_req_t got, input l2_req_t exp);
		if (got !== exp)
		begin
			$display("ERR l2_req_o: got %h expected %h", got, exp);
			errors++;
		end
	endtask

	task automatic check_strand(input strand_t got, input strand_t exp);
		if (got !== exp)
		begin
			$display("ERR l2_req_o.strand: got %h expected %h", got, exp);
			errors++;
		end
	endtask

	// Payload the L2 must see for a store that the buffer takes
	function automatic l2_req_t expected_l2(input strand_t s, input logic sync,
		input logic [`STBUF_TAG_W-1:0] tag, input logic [`STBUF_SET_W-1:0] set,
		input logic [31:0] word, input logic [`STBUF_MASK_W-1:0] mask);
		l2_req_t r;
		r.unit = 2'(`STBUF_UNIT_ID);
		r.strand = s;
		r.op = sync ? L2_OP_STORE_SYNC : L2_OP_STORE;
		r.address = {tag, set};
		r.data = {(`STBUF_LINE_W / 32){word}};
		r.mask = mask;
		return r;
	endfunction

	task automatic record_request(input l2_req_t got);
		grant_log.push_back(got.strand);
		m_req = got;
		if (!exp_valid[got.strand])
		begin
			$display("Unexpected L2 request from strand %0d", got.strand);
			errors++;
		end
		else
		begin
			check_l2_req(got, exp_l2[got.strand]);
			exp_valid[got.strand] = 1'b0;
		end
	endtask

	// Drives on the falling edge and returns one cycle later, when outputs are stable
	task automatic drive_request(input logic write, input logic sync, input strand_t s,
		input logic [`STBUF_TAG_W-1:0] tag, input logic [`STBUF_SET_W-1:0] set,
		input logic [31:0] word, input logic [`STBUF_MASK_W-1:0] mask);
		core_req.valid = 1'b1;
		core_req.write = write;
		core_req.sync = sync;
		core_req.strand = s;
		core_req.tag = tag;
		core_req.set = set;
		core_req.data = {(`STBUF_LINE_W / 32){word}};
		core_req.mask = mask;
		@(negedge clk);
		core_req = '0;
	endtask

	task automatic wait_resume(input strand_t s);
		int cycles;
		cycles = 0;
		while (resume[s] !== 1'b1 && cycles < WAIT_LIMIT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (resume[s] !== 1'b1)
		begin
			$display("Timed out waiting for the resume of strand %0d", s);
			errors++;
		end
		else
			for (int i = 0; i < `STBUF_STRANDS; i++)
				check_bit($sformatf("resume_o[%0d]", i), resume[i], i == int'(s));
	endtask

	// Model state is only sampled on rising edges, away from its own updates
	task automatic wait_drain();
		int cycles;
		int quiet;
		int open_reqs;
		cycles = 0;
		quiet = 0;
		while (quiet < QUIET_CYCLES && cycles < WAIT_LIMIT)
		begin
			@(posedge clk);
			cycles++;
			open_reqs = 0;
			for (int i = 0; i < `STBUF_STRANDS; i++)
				open_reqs += int'(exp_valid[i]);
			if (open_reqs == 0 && m_state == 0)
				quiet++;
			else
				quiet = 0;
		end
		if (quiet < QUIET_CYCLES)
		begin
			$display("Timed out waiting for the outstanding L2 requests to finish");
			errors++;
		end
		@(negedge clk);
	endtask

	// Hex digits of order, most significant first, give the last four strands granted
	task automatic check_order(input logic [31:0] order);
		int n;
		n = grant_log.size();
		if (n < `STBUF_STRANDS)
		begin
			$display("Only %0d L2 requests seen, too few to check the grant order", n);
			errors++;
		end
		else
			for (int k = 0; k < `STBUF_STRANDS; k++)
				check_strand(grant_log[n - `STBUF_STRANDS + k], order[4 * (3 - k) +: 2]);
	endtask

	always @(negedge clk)
	begin
		l2_rsp.valid = 1'b0;
		if (!arst_n_i)
		begin
			m_state = 0;
			l2_ack = 1'b0;
		end
		else
		begin
			case (m_state)
				0:
				begin
					if (l2_req_valid)
					begin
						record_request(l2_req);
						ack_wait = 1 + int'($urandom % 4);
						m_state = 1;
					end
				end
				1:
				begin
					ack_wait--;
					if (ack_wait == 0)
					begin
						l2_ack = 1'b1;
						m_state = 2;
					end
				end
				2:
				begin
					if (!l2_req_valid)
					begin
						l2_ack = 1'b0;
						rsp_wait = 2;
						m_state = 3;
					end
				end
				default:
				begin
					rsp_wait--;
					if (rsp_wait == 0)
					begin
						// Status is bit 0 of the line address
						l2_rsp.valid = 1'b1;
						l2_rsp.status = m_req.address[0];
						l2_rsp.unit = m_req.unit;
						l2_rsp.strand = m_req.strand;
						m_state = 0;
					end
				end
			endcase
		end
	end

	initial
	begin
		int steps;
		int b;
		logic done;
		logic issues;
		logic [3:0] act;
		strand_t s;
		logic [`STBUF_TAG_W-1:0] tag;
		logic [`STBUF_SET_W-1:0] set;
		logic [31:0] word;
		logic [`STBUF_MASK_W-1:0] mask;
		logic exp_rb;
		logic [31:0] exp_word;
		bypass_t exp_byp;

		void'($urandom(32'h7ddc_7f05));
		for (int i = 0; i < `STBUF_STRANDS; i++)
			exp_valid[i] = 1'b0;
		$readmemh("tests/store_patterns.hex", pat);

		repeat (5) @(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);

		done = 1'b0;
		steps = 0;
		while (!done && steps < MAX_STEPS)
		begin
			b = steps * STEP_W;
			act = pat[b][3:0];
			s = pat[b + 1][1:0];
			tag = pat[b + 2][`STBUF_TAG_W-1:0];
			set = pat[b + 3][`STBUF_SET_W-1:0];
			word = pat[b + 4][31:0];
			mask = pat[b + 5];
			exp_rb = pat[b + 6][0];
			exp_word = pat[b + 7][31:0];
			case (act)
				4'h0:
					done = 1'b1;
				4'h1, 4'h3:
				begin
					// A plain store goes to L2 when taken, a sync store on its first attempt
					issues = (act == 4'h1) ? !exp_rb : exp_rb;
					if (issues)
					begin
						exp_l2[s] = expected_l2(s, act == 4'h3, tag, set, word, mask);
						exp_valid[s] = 1'b1;
					end
					drive_request(1'b1, act == 4'h3, s, tag, set, word, mask);
					check_bit("rollback_o", rollback, exp_rb);
					if (act == 4'h3 && !exp_rb)
					begin
						exp_byp.data = {(`STBUF_LINE_W / 32){exp_word}};
						exp_byp.mask = '1;
						check_bypass(bypass, exp_byp);
					end
				end
				4'h2:
				begin
					drive_request(1'b0, 1'b0, s, tag, set, '0, '0);
					check_bit("rollback_o", rollback, exp_rb);
					exp_byp.data = {(`STBUF_LINE_W / 32){exp_word}};
					exp_byp.mask = mask;
					check_bypass(bypass, exp_byp);
				end
				4'h4:
					wait_resume(s);
				4'h5:
					wait_drain();
				4'h6:
					check_order(word);
				4'h7:
				begin
					test_num++;
					$display("Test %0d finished, %0d errors", test_num, errors - test_errors);
					test_errors = errors;
				end
				default:
				begin
					$display("Pattern step %0d has unknown action %0h", steps, act);
					errors++;
					done = 1'b1;
				end
			endcase
			steps++;
		end

		if (test_num == 0)
		begin
			$display("The pattern file ran no test");
			errors++;
		end

		errors += UUT.u_issue.u_props.failures;
		$display("Ran %0d tests in %0d steps, %0d errors", test_num, steps, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// ==== tests/store_patterns.hex ====
// action strand tag set data_word mask exp_rollback exp_bypass_word
// action 1 store, 2 load, 3 sync store, 4 wait resume, 5 drain L2, 6 grant order, 7 end test, 0 end
1 1 0ABCD 03 11223344 00000000FFFF0000 0 00000000
2 1 0ABCD 03 00000000 00000000FFFF0000 0 11223344
2 2 0ABCD 03 00000000 0000000000000000 0 00000000
2 1 0ABCD 04 00000000 0000000000000000 0 00000000
5 0 00000 00 00000000 0000000000000000 0 00000000
7 0 00000 00 00000000 0000000000000000 0 00000000
1 0 00123 01 A5A5A5A5 FFFFFFFFFFFFFFFF 0 00000000
1 0 00124 02 5A5A5A5A 00000000000000FF 1 00000000
4 0 00000 00 00000000 0000000000000000 0 00000000
1 0 00124 02 5A5A5A5A 00000000000000FF 0 00000000
5 0 00000 00 00000000 0000000000000000 0 00000000
7 0 00000 00 00000000 0000000000000000 0 00000000
3 3 00777 05 DEADBEEF 00000000000000F0 1 00000000
4 3 00000 00 00000000 0000000000000000 0 00000000
3 3 00777 05 DEADBEEF 00000000000000F0 0 00000001
5 0 00000 00 00000000 0000000000000000 0 00000000
7 0 00000 00 00000000 0000000000000000 0 00000000
1 2 01000 0A 22222222 FFFF000000000000 0 00000000
1 0 01000 0B 00000000 0F0F0F0F0F0F0F0F 0 00000000
1 3 01000 0C 33333333 00000000FFFFFFFF 0 00000000
1 1 01000 0D 11111111 000000000000FFFF 0 00000000
5 0 00000 00 00000000 0000000000000000 0 00000000
6 0 00000 00 00002301 0000000000000000 0 00000000
7 0 00000 00 00000000 0000000000000000 0 00000000
0 0 00000 00 00000000 0000000000000000 0 00000000

// ==== sim.f ====
+incdir+rtl
rtl/stbuf_pkg.sv
rtl/l2_pkg.sv
rtl/store_slot.sv
rtl/store_admit.sv
rtl/l2_store_issue.sv
rtl/store_buffer.sv
tests/store_buffer_props.sv
tests/store_buffer_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f sim.f \
		--top-module store_buffer_tb -Mdir obj_dir
	./obj_dir/Vstore_buffer_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
